// ==== hdl/rp_pkg.sv ====
// shared widths and types for the analog datapath and the system bus
// region numbers, housekeeping offsets and the address union

`default_nettype none

package rp_pkg;

  // sample widths
  localparam int SAMPLE_W = 14;           // adc, dac, generator, controller
  localparam int SUM_W    = SAMPLE_W + 1; // one guard bit for the sum

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // system bus
  localparam int BUS_ADDR_W = 32;
  localparam int BUS_DATA_W = 32;
  localparam int N_REGIONS  = 8;
  localparam int REGION_W   = $clog2(N_REGIONS); // 3 bits of region select
  localparam int OFFSET_W   = 20;               // 1 MB per region

  localparam logic [REGION_W-1:0] REGION_HK = 3'd0;

  // address seen either flat or split into region and offset
  typedef union packed {
    logic [BUS_ADDR_W-1:0] flat;
    struct packed {
      logic [BUS_ADDR_W-REGION_W-OFFSET_W-1:0] rsvd;   // top bits, ignored
      logic [REGION_W-1:0]                     region;
      logic [OFFSET_W-1:0]                     offset;
    } part;
  } sys_addr_u;

  // housekeeping register map
  localparam logic [OFFSET_W-1:0] HK_ID_OFS   = 20'h0_0000;
  localparam logic [OFFSET_W-1:0] HK_LOOP_OFS = 20'h0_0004;
  localparam logic [OFFSET_W-1:0] HK_LED_OFS  = 20'h0_0008;

  localparam int LED_W = 8;

endpackage

`default_nettype wire

// ==== hdl/sys_bus_if.sv ====
// one region of the system bus, strobes from master, response from region

`timescale 1ns/1ns
`default_nettype none

interface sys_bus_if;

  rp_pkg::sys_addr_u                 addr;   // full address, region + offset
  logic [rp_pkg::BUS_DATA_W-1:0]     wdata;
  logic                              wen;    // single cycle write strobe
  logic                              ren;    // single cycle read strobe
  logic [rp_pkg::BUS_DATA_W-1:0]     rdata;  // valid with ack on reads
  logic                              ack;    // one cycle after strobe
  logic                              err;

  // decoder side
  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  // register block side
  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

`default_nettype wire

// ==== hdl/sys_bus_decoder.sv ====
// system bus region decoder and response mux
// regions other than housekeeping are answered here with zero data

`timescale 1ns/1ns
`default_nettype none

module sys_bus_decoder (
  input  wire                            adc_clk,
  input  wire                            reset_i,
  // master side
  input  rp_pkg::sys_addr_u              sys_addr_i,
  input  wire [rp_pkg::BUS_DATA_W-1:0]   sys_wdata_i,
  input  wire                            sys_wen_i,
  input  wire                            sys_ren_i,
  output logic [rp_pkg::BUS_DATA_W-1:0]  sys_rdata_o,
  output logic                           sys_ack_o,
  output logic                           sys_err_o,
  // housekeeping region
  sys_bus_if.master                      hk_bus
);

  logic                        strobe;     // any access this cycle
  logic                        sel_hk;     // access targets region 0
  logic [rp_pkg::REGION_W-1:0] region_q;   // region of the pending access
  logic                        stub_ack_q; // local answer, empty regions

  assign strobe = sys_wen_i | sys_ren_i;
  assign sel_hk = (sys_addr_i.part.region == rp_pkg::REGION_HK);

  // forward to housekeeping, strobes only when it is addressed
  assign hk_bus.addr.flat = sys_addr_i.flat;
  assign hk_bus.wdata     = sys_wdata_i;
  assign hk_bus.wen       = sys_wen_i & sel_hk;
  assign hk_bus.ren       = sys_ren_i & sel_hk;

  ////////////////////////////////////////////////////////////////////////////
  // remember target region, answer empty regions
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      region_q   <= '0;
      stub_ack_q <= 1'b0;
    end
    else
    begin
      if (strobe)
        region_q <= sys_addr_i.part.region;  // steers the mux on ack cycle
      stub_ack_q <= strobe & ~sel_hk;
    end
  end

  // response mux
  always_comb
  begin
    if (region_q == rp_pkg::REGION_HK)
    begin
      sys_rdata_o = hk_bus.rdata;
      sys_ack_o   = hk_bus.ack;
      sys_err_o   = hk_bus.err;
    end
    else
    begin
      sys_rdata_o = '0;          // unpopulated, reads as zero
      sys_ack_o   = stub_ack_q;
      sys_err_o   = 1'b0;
    end
  end

  // ack on the master bus is always the answer to last cycle's strobe
  a_ack_after_strobe: assert property (@(posedge adc_clk) disable iff (reset_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i));

endmodule

`default_nettype wire

// ==== hdl/rp_housekeeping.sv ====
// housekeeping registers on region 0
// identification word, digital loopback switch and LEDs

`timescale 1ns/1ns
`default_nettype none

module rp_housekeeping #(
  parameter logic [rp_pkg::BUS_DATA_W-1:0] HK_ID = 32'h5250_0001
) (
  input  wire                         adc_clk,
  input  wire                         reset_i,
  sys_bus_if.slave                    bus,
  output logic                        digital_loop_o,  // dac codes into adc path
  output logic [rp_pkg::LED_W-1:0]    led_o
);

  logic [rp_pkg::OFFSET_W-1:0]   offset;
  logic                          loop_q;
  logic [rp_pkg::LED_W-1:0]      led_q;
  logic [rp_pkg::BUS_DATA_W-1:0] rdata_q;
  logic                          ack_q;

  assign offset = bus.addr.part.offset;  // region bits already decoded

  ////////////////////////////////////////////////////////////////////////////
  // register writes and read data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      loop_q  <= 1'b0;
      led_q   <= '0;
      rdata_q <= '0;
      ack_q   <= 1'b0;
    end
    else
    begin
      ack_q <= bus.wen | bus.ren;   // fixed one cycle latency
      if (bus.wen)
      begin
        case (offset)
          rp_pkg::HK_LOOP_OFS: loop_q <= bus.wdata[0];
          rp_pkg::HK_LED_OFS:  led_q  <= bus.wdata[rp_pkg::LED_W-1:0];
          default: ;                  // id is read only
        endcase
      end
      if (bus.ren)
      begin
        case (offset)
          rp_pkg::HK_ID_OFS:   rdata_q <= HK_ID;
          rp_pkg::HK_LOOP_OFS: rdata_q <= {{(rp_pkg::BUS_DATA_W-1){1'b0}}, loop_q};
          rp_pkg::HK_LED_OFS:  rdata_q <= {{(rp_pkg::BUS_DATA_W-rp_pkg::LED_W){1'b0}}, led_q};
          default:             rdata_q <= '0;
        endcase
      end
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;    // every offset answers

  assign digital_loop_o = loop_q;
  assign led_o          = led_q;

  // decoder never issues read and write in the same cycle
  a_no_rw_overlap: assert property (@(posedge adc_clk) disable iff (reset_i)
    !(bus.wen && bus.ren));

endmodule

`default_nettype wire

// ==== hdl/adc_frontend.sv ====
// adc capture, channel swap, lsb clearing and digital loopback select

`timescale 1ns/1ns
`default_nettype none

module adc_frontend (
  input  wire              adc_clk,
  input  wire              reset_i,
  input  rp_pkg::sample_t  adc_dat_a_i,     // raw words from the adc pins
  input  rp_pkg::sample_t  adc_dat_b_i,
  input  rp_pkg::sample_t  loop_a_i,        // combinational dac codes
  input  rp_pkg::sample_t  loop_b_i,
  input  wire              digital_loop_i,
  output rp_pkg::sample_t  adc_a_o,
  output rp_pkg::sample_t  adc_b_o
);

  rp_pkg::sample_t adc_a_q;   // capture stage
  rp_pkg::sample_t adc_b_q;

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      adc_a_q <= '0;
      adc_b_q <= '0;
      adc_a_o <= '0;
      adc_b_o <= '0;
    end
    else
    begin
      adc_a_q <= adc_dat_a_i;
      adc_b_q <= adc_dat_b_i;
      // input b feeds channel a and vice versa, two noisy lsbs dropped
      adc_a_o <= digital_loop_i ? loop_a_i : {adc_b_q[rp_pkg::SAMPLE_W-1:2], 2'b00};
      adc_b_o <= digital_loop_i ? loop_b_i : {adc_a_q[rp_pkg::SAMPLE_W-1:2], 2'b00};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dac_backend.sv ====
// dac back end, generator plus controller sum with saturation
// inversion to the neg-slope dac code, output channel swap, dac reset

`timescale 1ns/1ns
`default_nettype none

module dac_backend (
  input  wire              adc_clk,
  input  wire              reset_i,
  input  rp_pkg::sample_t  gen_a_i,
  input  rp_pkg::sample_t  gen_b_i,
  input  rp_pkg::sample_t  ctl_a_i,
  input  rp_pkg::sample_t  ctl_b_i,
  output rp_pkg::sample_t  code_a_o,     // unregistered, for loopback
  output rp_pkg::sample_t  code_b_o,
  output rp_pkg::sample_t  dac_dat_a_o,
  output rp_pkg::sample_t  dac_dat_b_o,
  output logic             dac_reset_o
);

  logic [rp_pkg::SUM_W-1:0] sum_a;   // sign extended sums, never wrap
  logic [rp_pkg::SUM_W-1:0] sum_b;
  rp_pkg::sample_t          code_a_q;
  rp_pkg::sample_t          code_b_q;

  // clamp to -8192..8191, then invert for the dac
  function automatic rp_pkg::sample_t sat_inv(input logic [rp_pkg::SUM_W-1:0] s);
    rp_pkg::sample_t clamped;
    if (s[rp_pkg::SUM_W-1] != s[rp_pkg::SUM_W-2])   // top two bits differ, overflow
      clamped = {s[rp_pkg::SUM_W-1], {(rp_pkg::SAMPLE_W-1){~s[rp_pkg::SUM_W-1]}}};
    else
      clamped = s[rp_pkg::SAMPLE_W-1:0];
    return ~clamped;
  endfunction

  assign sum_a = {gen_a_i[rp_pkg::SAMPLE_W-1], gen_a_i} + {ctl_a_i[rp_pkg::SAMPLE_W-1], ctl_a_i};
  assign sum_b = {gen_b_i[rp_pkg::SAMPLE_W-1], gen_b_i} + {ctl_b_i[rp_pkg::SAMPLE_W-1], ctl_b_i};

  assign code_a_o = sat_inv(sum_a);
  assign code_b_o = sat_inv(sum_b);

  ////////////////////////////////////////////////////////////////////////////
  // two register stages, swap on the second
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      code_a_q    <= '0;
      code_b_q    <= '0;
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end
    else
    begin
      code_a_q    <= code_a_o;
      code_b_q    <= code_b_o;
      dac_dat_a_o <= code_b_q;   // ch b drives dac a
      dac_dat_b_o <= code_a_q;   // ch a drives dac b
    end
  end

  always_ff @(posedge adc_clk)
    dac_reset_o <= reset_i;     // held one cycle past reset release

  a_dac_reset: assert property (@(posedge adc_clk) reset_i |=> dac_reset_o);

endmodule

`default_nettype wire

// ==== hdl/rp_analog_top.sv ====
// analog top level, adc front end, dac back end
// system bus decoder and housekeeping registers

`timescale 1ns/1ns
`default_nettype none

module rp_analog_top #(
  parameter logic [rp_pkg::BUS_DATA_W-1:0] HK_ID = 32'h5250_0001
) (
  input  wire                            adc_clk,
  input  wire                            reset_i,
  // adc
  input  rp_pkg::sample_t                adc_dat_a_i,
  input  rp_pkg::sample_t                adc_dat_b_i,
  output rp_pkg::sample_t                adc_a_o,      // to acquisition
  output rp_pkg::sample_t                adc_b_o,
  // generator and controller samples
  input  rp_pkg::sample_t                gen_a_i,
  input  rp_pkg::sample_t                gen_b_i,
  input  rp_pkg::sample_t                ctl_a_i,
  input  rp_pkg::sample_t                ctl_b_i,
  // dac
  output rp_pkg::sample_t                dac_dat_a_o,
  output rp_pkg::sample_t                dac_dat_b_o,
  output logic                           dac_reset_o,
  output logic [rp_pkg::LED_W-1:0]       led_o,
  // system bus master
  input  wire [rp_pkg::BUS_ADDR_W-1:0]   sys_addr_i,
  input  wire [rp_pkg::BUS_DATA_W-1:0]   sys_wdata_i,
  input  wire                            sys_wen_i,
  input  wire                            sys_ren_i,
  output logic [rp_pkg::BUS_DATA_W-1:0]  sys_rdata_o,
  output logic                           sys_ack_o,
  output logic                           sys_err_o
);

  rp_pkg::sample_t code_a;        // dac codes before the output registers
  rp_pkg::sample_t code_b;
  logic            digital_loop;

  sys_bus_if hk_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_sys_bus_decoder (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk_bus      (hk_bus.master)
  );

  rp_housekeeping #(.HK_ID(HK_ID)) i_rp_housekeeping (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .bus            (hk_bus.slave),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend i_adc_frontend (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .loop_a_i       (code_a),
    .loop_b_i       (code_b),
    .digital_loop_i (digital_loop),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  dac_backend i_dac_backend (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .gen_a_i     (gen_a_i),
    .gen_b_i     (gen_b_i),
    .ctl_a_i     (ctl_a_i),
    .ctl_b_i     (ctl_b_i),
    .code_a_o    (code_a),
    .code_b_o    (code_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_reset_o (dac_reset_o)
  );

endmodule

`default_nettype wire

// ==== dv/rp_analog_tb.sv ====
// testbench for the analog top level, table of samples and bus accesses
// reference model for adc/dac paths, housekeeping registers and empty regions

`timescale 1ns/1ns
`default_nettype none

module rp_analog_tb;

  localparam logic [31:0] TB_HK_ID = 32'hA5C3_0F17;
  localparam logic [1:0]  K_SAMPLE = 2'd0;
  localparam logic [1:0]  K_WRITE  = 2'd1;
  localparam logic [1:0]  K_READ   = 2'd2;
  localparam logic [13:0] S_MAX    = 14'h1FFF;   // +8191
  localparam logic [13:0] S_MIN    = 14'h2000;   // -8192
  localparam logic [13:0] S_NEG1   = 14'h3FFF;

  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [13:0] adc_a;
    logic [13:0] adc_b;
    logic [13:0] gen_a;
    logic [13:0] gen_b;
    logic [13:0] ctl_a;
    logic [13:0] ctl_b;
  } entry_t;

  logic adc_clk;
  logic reset_i;
  logic [13:0] adc_dat_a_i, adc_dat_b_i, gen_a_i, gen_b_i, ctl_a_i, ctl_b_i;
  logic [13:0] adc_a_o, adc_b_o, dac_dat_a_o, dac_dat_b_o;
  logic        dac_reset_o;
  logic [7:0]  led_o;
  logic [31:0] sys_addr_i, sys_wdata_i, sys_rdata_o;
  logic        sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;

  entry_t      entries[$];
  logic [31:0] rng_state = 32'h8d86_4fe2;
  int          cycles = 0;
  int          cycle_limit = 20;
  // reference model state
  logic        loop_ref = 1'b0;
  logic [7:0]  led_ref = 8'h00;
  logic [13:0] prev_adc_a = '0, prev_adc_b = '0;   // last driven adc pair
  logic [13:0] prev_code_a, prev_code_b;           // codes of last gen/ctl drive

  rp_analog_top #(.HK_ID(TB_HK_ID)) i_rp_analog_top (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: no end of test after %0d cycles", cycle_limit);
      $display("tests failed");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model and helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // clamp g+c to the 14-bit range, then invert
  function automatic logic [13:0] dac_code(input logic signed [13:0] g,
                                          input logic signed [13:0] c);
    int sum;
    sum = int'(g) + int'(c);
    if (sum > 8191)
      sum = 8191;
    else if (sum < -8192)
      sum = -8192;
    return ~sum[13:0];
  endfunction

  function automatic logic [13:0] lsb_clear(input logic [13:0] x);
    return {x[13:2], 2'b00};
  endfunction

  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    if (addr[22:20] != 3'd0)
      return 32'h0;                  // empty region
    case (addr[19:0])
      rp_pkg::HK_ID_OFS:   return TB_HK_ID;
      rp_pkg::HK_LOOP_OFS: return {31'b0, loop_ref};
      rp_pkg::HK_LED_OFS:  return {24'b0, led_ref};
      default:             return 32'h0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("tests failed");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic add_sample(input logic [13:0] aa, ab, ga, gb, ca, cb);
    entries.push_back('{K_SAMPLE, 32'h0, 32'h0, aa, ab, ga, gb, ca, cb});
  endtask

  task automatic add_bus(input logic [1:0] kind, input logic [31:0] addr, input logic [31:0] data);
    entries.push_back('{kind, addr, data, 14'h0, 14'h0, 14'h0, 14'h0, 14'h0, 14'h0});
  endtask

  task automatic add_random(input int count);
    logic [13:0] r[6];
    for (int n = 0; n < count; n++)
    begin
      for (int k = 0; k < 6; k++)
      begin
        rng_state = xorshift32(rng_state);
        r[k] = rng_state[13:0];
      end
      add_sample(r[0], r[1], r[2], r[3], r[4], r[5]);
    end
  endtask

  task automatic build_table();
    add_bus(K_READ, 32'h0000_0004, 0);     // loop off after reset
    add_bus(K_READ, 32'h0000_0000, 0);     // id
    add_bus(K_READ, 32'h0000_0008, 0);
    add_bus(K_READ, 32'h0000_000C, 0);     // unknown offset
    // corners: overflow both ways, exact limits
    add_sample(14'h3FFF, 14'h2000, S_MAX, S_MIN, S_MAX, S_MIN);
    add_sample(14'h1FFF, 14'h0003, S_MAX, S_MIN, 14'h0001, S_NEG1);
    add_sample(14'h0002, 14'h2001, S_MAX, S_MIN, 14'h0000, 14'h0000);
    add_sample(14'h0000, 14'h0000, 14'd4000, S_NEG1, -14'sd4000, 14'h0001);
    add_random(10);
    add_bus(K_WRITE, 32'h0000_0008, 32'h0000_00A5);
    add_bus(K_READ,  32'h0000_0008, 0);
    add_bus(K_WRITE, 32'h0000_0004, 32'h0000_0001);   // loopback on
    add_bus(K_READ,  32'h0000_0004, 0);
    add_sample(14'h1234, 14'h0ABC, S_MAX, S_MIN, S_MAX, S_MIN);
    add_sample(14'h3FFF, 14'h0000, 14'h0000, S_MAX, 14'h0000, 14'h0001);
    add_random(6);
    add_bus(K_WRITE, 32'h0000_0004, 32'h0000_0000);   // loopback off
    add_random(4);
    add_bus(K_WRITE, 32'h0030_0004, 32'h0000_0001);   // region 3, no effect
    for (int r = 1; r < 8; r++)
      add_bus(K_READ, (32'(r) << 20) | 32'h4, 0);
    add_bus(K_READ,  32'h0000_0004, 0);
    add_bus(K_WRITE, 32'h0000_0008, 32'h1234_5677);   // only low byte kept
    add_bus(K_READ,  32'h0000_0008, 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // apply one table entry, called 10 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_sample(input entry_t e, input int idx);
    logic [13:0] code_a;
    logic [13:0] code_b;
    code_a = dac_code(e.gen_a, e.ctl_a);
    code_b = dac_code(e.gen_b, e.ctl_b);
    {adc_dat_a_i, adc_dat_b_i} = {e.adc_a, e.adc_b};
    {gen_a_i, gen_b_i, ctl_a_i, ctl_b_i} = {e.gen_a, e.gen_b, e.ctl_a, e.ctl_b};
    @(posedge adc_clk);
    #10;
    // one edge in, old pair still in the pipes
    compare($sformatf("entry %0d dac_a stage 1", idx), 32'(prev_code_b), 32'(dac_dat_a_o));
    compare($sformatf("entry %0d dac_b stage 1", idx), 32'(prev_code_a), 32'(dac_dat_b_o));
    compare($sformatf("entry %0d adc_a stage 1", idx),
            32'(loop_ref ? code_a : lsb_clear(prev_adc_b)), 32'(adc_a_o));
    compare($sformatf("entry %0d adc_b stage 1", idx),
            32'(loop_ref ? code_b : lsb_clear(prev_adc_a)), 32'(adc_b_o));
    compare($sformatf("entry %0d idle ack stage 1", idx), 32'(0), 32'(sys_ack_o));
    @(posedge adc_clk);
    #10;
    compare($sformatf("entry %0d dac_a", idx), 32'(code_b), 32'(dac_dat_a_o));  // swapped
    compare($sformatf("entry %0d dac_b", idx), 32'(code_a), 32'(dac_dat_b_o));
    compare($sformatf("entry %0d adc_a", idx),
            32'(loop_ref ? code_a : lsb_clear(e.adc_b)), 32'(adc_a_o));
    compare($sformatf("entry %0d adc_b", idx),
            32'(loop_ref ? code_b : lsb_clear(e.adc_a)), 32'(adc_b_o));
    compare($sformatf("entry %0d idle ack", idx), 32'(0), 32'(sys_ack_o));
    compare($sformatf("entry %0d led", idx), 32'(led_ref), 32'(led_o));
    {prev_adc_a, prev_adc_b, prev_code_a, prev_code_b} = {e.adc_a, e.adc_b, code_a, code_b};
  endtask

  task automatic apply_bus(input entry_t e, input int idx);
    logic [31:0] exp_rdata;
    exp_rdata = expected_read(e.addr);
    sys_addr_i  = e.addr;
    sys_wdata_i = e.data;
    sys_wen_i   = (e.kind == K_WRITE);
    sys_ren_i   = (e.kind == K_READ);
    @(posedge adc_clk);
    #10;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    if (e.kind == K_WRITE && e.addr[22:20] == 3'd0)
    begin
      if (e.addr[19:0] == rp_pkg::HK_LOOP_OFS)
        loop_ref = e.data[0];
      else if (e.addr[19:0] == rp_pkg::HK_LED_OFS)
        led_ref = e.data[7:0];
    end
    compare($sformatf("entry %0d ack", idx), 32'(1), 32'(sys_ack_o));
    compare($sformatf("entry %0d err", idx), 32'(0), 32'(sys_err_o));
    compare($sformatf("entry %0d led", idx), 32'(led_ref), 32'(led_o));  // same cycle as ack
    if (e.kind == K_READ)
      compare($sformatf("entry %0d rdata", idx), exp_rdata, sys_rdata_o);
  endtask

  initial
  begin
    reset_i = 1'b1;
    {adc_dat_a_i, adc_dat_b_i, gen_a_i, gen_b_i, ctl_a_i, ctl_b_i} = '0;
    {sys_addr_i, sys_wdata_i, sys_wen_i, sys_ren_i} = '0;
    // idle zero inputs fill the dac pipe with the code of a zero sum
    prev_code_a = dac_code(gen_a_i, ctl_a_i);
    prev_code_b = dac_code(gen_b_i, ctl_b_i);
    build_table();
    cycle_limit = 4 * entries.size() + 20;
    @(posedge adc_clk);
    #10;
    compare("reset dac_reset", 32'(1), 32'(dac_reset_o));
    @(posedge adc_clk);
    #10;
    reset_i = 1'b0;                      // two cycles of reset
    compare("reset dac_reset held", 32'(1), 32'(dac_reset_o));
    compare("reset led", 32'(0), 32'(led_o));
    @(posedge adc_clk);
    #10;
    compare("dac_reset released", 32'(0), 32'(dac_reset_o));
    for (int i = 0; i < entries.size(); i++)
    begin
      if (entries[i].kind == K_SAMPLE)
        apply_sample(entries[i], i);
      else
        apply_bus(entries[i], i);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rp_analog.f ====
hdl/rp_pkg.sv
hdl/sys_bus_if.sv
hdl/sys_bus_decoder.sv
hdl/rp_housekeeping.sv
hdl/adc_frontend.sv
hdl/dac_backend.sv
hdl/rp_analog_top.sv
dv/rp_analog_tb.sv

// ==== Makefile ====
# Verilator build for the analog top level testbench

VERILATOR ?= verilator
TOP       ?= rp_analog_tb
FILELIST  ?= rp_analog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "all tests passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
